// ==== controlUnit_params.svh ====
`ifndef CONTROL_UNIT_PARAMS_SVH
`define CONTROL_UNIT_PARAMS_SVH

`define INSTR_WIDTH  32
`define STATE_WIDTH  8
`define CTRL_WIDTH   25                // N, INV, STS_SEL, CR, seven lines, ALU_OP
`define NEXT_WIDTH   3
`define STS_WIDTH    2
`define ALU_OP_WIDTH 4

// Microword fields, low bit of each field
`define N_POS         22               // Next-state code, 3 bits
`define INV_POS       21
`define STS_SEL_POS   19               // 2 bits
`define CR_POS        11               // Jump target, 8 bits
`define RF_LOAD_POS   10
`define IR_LOAD_POS   9
`define MAR_LOAD_POS  8
`define MDR_LOAD_POS  7
`define MEM_RW_POS    6
`define MEM_VALID_POS 5
`define SR_LOAD_POS   4
`define ALU_OP_POS    0                // 4 bits

`define ST_FETCH0      8'd0
`define ST_FETCH1      8'd1
`define ST_FETCH2      8'd2
`define ST_FETCH3      8'd3
`define ST_COND        8'd4
`define ST_ALU_REG     8'd5
`define ST_ALU_SHIFT   8'd6
`define ST_ALU_IMM     8'd7
`define ST_TEST_REG    8'd8
`define ST_TEST_SHIFT  8'd9
`define ST_TEST_IMM    8'd10
`define ST_BRANCH      8'd14
`define ST_BRANCH_LINK 8'd15

`define NS_DECODE       3'd0           // Decoder state
`define NS_FETCH        3'd1           // Back to state 0
`define NS_JUMP         3'd2           // CR field
`define NS_INC          3'd3           // Incrementer
`define NS_DECODE_IF    3'd4           // Decoder state if tested bit, else 0
`define NS_WAIT         3'd5           // Incrementer if tested bit, else hold
`define NS_FETCH_UNLESS 3'd6           // Incrementer if tested bit, else 0

`endif

// ==== instrPkg.sv ====
`include "controlUnit_params.svh"

package instrPkg;

    typedef logic [2:0] instrClassT;   // Bits 27:25

    // One instruction word, read either as data processing or as branch
    typedef union packed {
        struct packed {
            logic [3:0]  cond;
            instrClassT  instrClass;
            logic [3:0]  opcode;
            logic        setFlags;
            logic [3:0]  rn;
            logic [3:0]  rd;
            logic [11:0] operand2;     // Bit 4 set means register shift
        } dp;
        struct packed {
            logic [3:0]  cond;
            instrClassT  instrClass;
            logic        link;
            logic [`INSTR_WIDTH-9:0] offset;   // Rest of the word
        } br;
    } instrT;

endpackage

// ==== microcodePkg.sv ====
`include "controlUnit_params.svh"

package microcodePkg;

    typedef logic [`STATE_WIDTH-1:0] stateT;     // Microstate number, also ROM address
    typedef logic [`CTRL_WIDTH-1:0]  ctrlWordT;  // One microword
    typedef logic [`NEXT_WIDTH-1:0]  nextCodeT;  // Next-state code

endpackage

// ==== instrDecoder.sv ====
`timescale 1ns/1ps
`include "controlUnit_params.svh"

module instrDecoder (
    input  instrPkg::instrT     instr,
    output microcodePkg::stateT execState
);
    import instrPkg::*;
    import microcodePkg::*;

    instrClassT instrClass;
    logic       regShift;
    logic       isTest;
    logic       link;
    stateT      shiftState;
    stateT      immState;

    assign instrClass = instr.dp.instrClass;
    assign regShift   = instr.dp.operand2[4];       // Register vs immediate shift
    assign isTest     = (instr.dp.opcode[3:2] == 2'b10);   // TST, TEQ, CMP, CMN
    assign link       = instr.br.link;

    // Register and immediate-shift forms of class 000
    always_comb begin
        if (isTest) begin
            if (regShift) begin
                shiftState = `ST_TEST_REG;
            end else begin
                shiftState = `ST_TEST_SHIFT;
            end
        end else begin
            if (regShift) begin
                shiftState = `ST_ALU_REG;
            end else begin
                shiftState = `ST_ALU_SHIFT;
            end
        end
    end

    assign immState = isTest ? `ST_TEST_IMM : `ST_ALU_IMM;

    always_comb begin
        case (instrClass)
            3'b000: begin
                execState = shiftState;
            end
            3'b001: begin
                execState = immState;
            end
            3'b101: begin
                if (link) begin
                    execState = `ST_BRANCH_LINK;
                end else begin
                    execState = `ST_BRANCH;
                end
            end
            default: begin
                execState = `ST_FETCH0;             // Loads, stores and the rest
            end
        endcase
    end

endmodule

// ==== microSequencer.sv ====
`timescale 1ns/1ps
`include "controlUnit_params.svh"

module microSequencer (
    input  logic                   CLK,
    input  logic                   CLR,
    input  microcodePkg::stateT    execState,
    input  microcodePkg::nextCodeT nextCode,
    input  logic                   inv,
    input  logic [`STS_WIDTH-1:0]  stsSel,
    input  microcodePkg::stateT    jumpTarget,
    input  logic                   moc,
    input  logic                   condPass,
    output microcodePkg::stateT    state
);
    import microcodePkg::*;

    logic  pickedSts;
    logic  testBit;
    stateT incState;
    stateT nextState;

    // Status mux
    always_comb begin
        case (stsSel)
            2'b00:   pickedSts = moc;
            2'b01:   pickedSts = condPass;
            2'b10:   pickedSts = 1'b0;
            default: pickedSts = 1'b1;
        endcase
    end

    assign testBit = pickedSts ^ inv;

    // Incrementer
    assign incState = stateT'(state + 1'b1);

    always_comb begin
        case (nextCode)
            `NS_DECODE: begin
                nextState = execState;
            end
            `NS_FETCH: begin
                nextState = `ST_FETCH0;
            end
            `NS_JUMP: begin
                nextState = jumpTarget;
            end
            `NS_INC: begin
                nextState = incState;
            end
            `NS_DECODE_IF: begin
                nextState = testBit ? execState : `ST_FETCH0;   // Failed condition refetches
            end
            `NS_WAIT: begin
                nextState = testBit ? incState : state;         // Hold until the bit is set
            end
            `NS_FETCH_UNLESS: begin
                nextState = testBit ? incState : `ST_FETCH0;
            end
            default: begin
                nextState = `ST_FETCH0;
            end
        endcase
    end

    // State register
    always_ff @(posedge CLK or negedge CLR) begin
        if (!CLR) begin
            state <= `ST_FETCH0;
        end else begin
            state <= nextState;
        end
    end

endmodule

// ==== controlStore.sv ====
`timescale 1ns/1ps
`include "controlUnit_params.svh"

module controlStore (
    input  logic                     CLK,
    input  logic                     CLR,
    input  microcodePkg::stateT      state,
    output microcodePkg::nextCodeT   nextCode,
    output logic                     inv,
    output logic [`STS_WIDTH-1:0]    stsSel,
    output microcodePkg::stateT      jumpTarget,
    output microcodePkg::stateT      stateOut,
    output logic                     rfLoad,
    output logic                     irLoad,
    output logic                     marLoad,
    output logic                     mdrLoad,
    output logic                     memRw,
    output logic                     memValid,
    output logic                     srLoad,
    output logic [`ALU_OP_WIDTH-1:0] aluOp
);
    import microcodePkg::*;

    // Control line masks, in the order rf, ir, mar, mdr, rw, valid, sr
    localparam logic [6:0] lineNone  = 7'b0000000;
    localparam logic [6:0] lineRf    = 7'b1000000;
    localparam logic [6:0] lineIr    = 7'b0100000;
    localparam logic [6:0] lineMar   = 7'b0010000;
    localparam logic [6:0] lineMdr   = 7'b0001000;
    localparam logic [6:0] lineRw    = 7'b0000100;   // High means read
    localparam logic [6:0] lineValid = 7'b0000010;
    localparam logic [6:0] lineSr    = 7'b0000001;

    localparam logic [`STS_WIDTH-1:0] selMoc  = 2'b00;
    localparam logic [`STS_WIDTH-1:0] selCond = 2'b01;
    localparam logic [`STS_WIDTH-1:0] selNone = 2'b10;   // Constant 0

    localparam logic [`ALU_OP_WIDTH-1:0] aluNone  = 4'd0;
    localparam logic [`ALU_OP_WIDTH-1:0] aluArith = 4'd1;
    localparam logic [`ALU_OP_WIDTH-1:0] aluTest  = 4'd2;

    function automatic ctrlWordT makeWord(
        input nextCodeT                  next,
        input logic [`STS_WIDTH-1:0]     sel,
        input logic                      invBit,
        input stateT                     target,
        input logic [6:0]                lines,
        input logic [`ALU_OP_WIDTH-1:0]  alu
    );
        ctrlWordT word;
        word = '0;
        word[`N_POS +: `NEXT_WIDTH]        = next;
        word[`INV_POS]                     = invBit;
        word[`STS_SEL_POS +: `STS_WIDTH]   = sel;
        word[`CR_POS +: `STATE_WIDTH]      = target;
        word[`RF_LOAD_POS]                 = lines[6];
        word[`IR_LOAD_POS]                 = lines[5];
        word[`MAR_LOAD_POS]                = lines[4];
        word[`MDR_LOAD_POS]                = lines[3];
        word[`MEM_RW_POS]                  = lines[2];
        word[`MEM_VALID_POS]               = lines[1];
        word[`SR_LOAD_POS]                 = lines[0];
        word[`ALU_OP_POS +: `ALU_OP_WIDTH] = alu;
        return word;
    endfunction

    localparam ctrlWordT fetch0Word =
        makeWord(`NS_INC, selNone, 1'b0, `ST_FETCH0, lineNone, aluNone);

    ctrlWordT romWord;

    // Microprogram ROM
    always_comb begin
        case (state)
            `ST_FETCH1: romWord = makeWord(`NS_INC, selNone, 1'b0, `ST_FETCH0,
                                           lineMar, aluNone);
            `ST_FETCH2: romWord = makeWord(`NS_INC, selNone, 1'b0, `ST_FETCH0,
                                           lineValid | lineRw, aluNone);
            `ST_FETCH3: romWord = makeWord(`NS_WAIT, selMoc, 1'b0, `ST_FETCH0,
                                           lineValid | lineMdr | lineIr, aluNone);
            `ST_COND: romWord = makeWord(`NS_DECODE_IF, selCond, 1'b0, `ST_FETCH0,
                                         lineNone, aluNone);
            `ST_ALU_REG, `ST_ALU_SHIFT, `ST_ALU_IMM:
                romWord = makeWord(`NS_FETCH, selNone, 1'b0, `ST_FETCH0, lineRf, aluArith);
            `ST_TEST_REG, `ST_TEST_SHIFT, `ST_TEST_IMM:
                romWord = makeWord(`NS_FETCH, selNone, 1'b0, `ST_FETCH0, lineSr, aluTest);
            `ST_BRANCH:
                romWord = makeWord(`NS_FETCH, selNone, 1'b0, `ST_FETCH0, lineNone, aluNone);
            `ST_BRANCH_LINK:
                romWord = makeWord(`NS_FETCH, selNone, 1'b0, `ST_FETCH0, lineRf, aluNone);
            default: romWord = fetch0Word;    // Also covers state 0
        endcase
    end

    // Sequencing fields go straight back to the sequencer
    assign nextCode   = romWord[`N_POS +: `NEXT_WIDTH];
    assign inv        = romWord[`INV_POS];
    assign stsSel     = romWord[`STS_SEL_POS +: `STS_WIDTH];
    assign jumpTarget = romWord[`CR_POS +: `STATE_WIDTH];

    always_ff @(posedge CLK or negedge CLR) begin
        if (!CLR) begin
            stateOut <= `ST_FETCH0;
            rfLoad   <= 1'b0;
            irLoad   <= 1'b0;
            marLoad  <= 1'b0;
            mdrLoad  <= 1'b0;
            memRw    <= 1'b0;
            memValid <= 1'b0;
            srLoad   <= 1'b0;
            aluOp    <= aluNone;
        end else begin
            stateOut <= state;                 // Kept aligned with the lines
            rfLoad   <= romWord[`RF_LOAD_POS];
            irLoad   <= romWord[`IR_LOAD_POS];
            marLoad  <= romWord[`MAR_LOAD_POS];
            mdrLoad  <= romWord[`MDR_LOAD_POS];
            memRw    <= romWord[`MEM_RW_POS];
            memValid <= romWord[`MEM_VALID_POS];
            srLoad   <= romWord[`SR_LOAD_POS];
            aluOp    <= romWord[`ALU_OP_POS +: `ALU_OP_WIDTH];
        end
    end

endmodule

// ==== controlUnit.sv ====
`timescale 1ns/1ps
`include "controlUnit_params.svh"

module controlUnit (
    input  logic                     CLK,
    input  logic                     CLR,
    input  instrPkg::instrT          instr,
    input  logic                     moc,         // Memory operation complete
    input  logic                     condPass,
    output microcodePkg::stateT      state,
    output logic                     rfLoad,
    output logic                     irLoad,
    output logic                     marLoad,
    output logic                     mdrLoad,
    output logic                     memRw,
    output logic                     memValid,
    output logic                     srLoad,
    output logic [`ALU_OP_WIDTH-1:0] aluOp
);
    import microcodePkg::*;

    stateT                 execState;
    stateT                 seqState;      // Undelayed state register
    nextCodeT              nextCode;
    logic                  inv;
    logic [`STS_WIDTH-1:0] stsSel;
    stateT                 jumpTarget;

    instrDecoder decoderInst (
        .instr     (instr),
        .execState (execState)
    );

    microSequencer sequencerInst (
        .CLK        (CLK),
        .CLR        (CLR),
        .execState  (execState),
        .nextCode   (nextCode),
        .inv        (inv),
        .stsSel     (stsSel),
        .jumpTarget (jumpTarget),
        .moc        (moc),
        .condPass   (condPass),
        .state      (seqState)
    );

    controlStore storeInst (
        .CLK        (CLK),
        .CLR        (CLR),
        .state      (seqState),
        .nextCode   (nextCode),
        .inv        (inv),
        .stsSel     (stsSel),
        .jumpTarget (jumpTarget),
        .stateOut   (state),
        .rfLoad     (rfLoad),
        .irLoad     (irLoad),
        .marLoad    (marLoad),
        .mdrLoad    (mdrLoad),
        .memRw      (memRw),
        .memValid   (memValid),
        .srLoad     (srLoad),
        .aluOp      (aluOp)
    );

endmodule

// ==== tbControlUnit.sv ====
`timescale 1ns/1ps
`include "controlUnit_params.svh"

module tbControlUnit;
    import instrPkg::*;
    import microcodePkg::*;

    localparam int cycleLimit = 400;          // Six tests of up to ~40 cycles, with margin
    localparam int waitLimit  = 30;           // Longest wait for one state

    // Control line masks in the order rf, ir, mar, mdr, rw, valid, sr
    localparam logic [6:0] linesNone   = 7'b0000000;
    localparam logic [6:0] linesFetch1 = 7'b0010000;
    localparam logic [6:0] linesFetch2 = 7'b0000110;
    localparam logic [6:0] linesFetch3 = 7'b0101010;
    localparam logic [6:0] linesRf     = 7'b1000000;
    localparam logic [6:0] linesSr     = 7'b0000001;

    localparam logic [`ALU_OP_WIDTH-1:0] aluNone  = 4'd0;
    localparam logic [`ALU_OP_WIDTH-1:0] aluArith = 4'd1;
    localparam logic [`ALU_OP_WIDTH-1:0] aluTest  = 4'd2;

    localparam logic [3:0] opAdd = 4'b0100;
    localparam logic [3:0] opCmp = 4'b1010;   // Test group, pattern 10xx

    logic                     CLK;
    logic                     CLR;
    instrT                    instr;
    logic                     moc;
    logic                     condPass;
    stateT                    state;
    logic                     rfLoad;
    logic                     irLoad;
    logic                     marLoad;
    logic                     mdrLoad;
    logic                     memRw;
    logic                     memValid;
    logic                     srLoad;
    logic [`ALU_OP_WIDTH-1:0] aluOp;

    int     errorCount  = 0;
    int     testCount   = 0;
    int     failedTests = 0;
    int     cycleCount;
    integer mocSeed     = 48;

    controlUnit dut_i (
        .CLK      (CLK),
        .CLR      (CLR),
        .instr    (instr),
        .moc      (moc),
        .condPass (condPass),
        .state    (state),
        .rfLoad   (rfLoad),
        .irLoad   (irLoad),
        .marLoad  (marLoad),
        .mdrLoad  (mdrLoad),
        .memRw    (memRw),
        .memValid (memValid),
        .srLoad   (srLoad),
        .aluOp    (aluOp)
    );

    initial begin
        CLK = 1'b0;
        forever #50 CLK = ~CLK;
    end

    function automatic instrT dpInstr(input instrClassT cls, input logic [3:0] opcode,
                                      input logic [11:0] op2);
        instrT word;
        word = '0;
        word.dp.cond       = 4'hE;            // Always
        word.dp.instrClass = cls;
        word.dp.opcode     = opcode;
        word.dp.rn         = 4'd1;
        word.dp.rd         = 4'd2;
        word.dp.operand2   = op2;
        return word;
    endfunction

    function automatic instrT brInstr(input logic link);
        instrT word;
        word = '0;
        word.br.cond       = 4'hE;
        word.br.instrClass = 3'b101;
        word.br.link       = link;
        word.br.offset     = 24'h000010;
        return word;
    endfunction

    task automatic checkState(input string name, input stateT expected, input stateT actual);
        if (actual !== expected) begin
            errorCount++;
            $display("Fail at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
        end
    endtask

    task automatic checkCtrl(input string name, input logic [`ALU_OP_WIDTH-1:0] expected,
                             input logic [`ALU_OP_WIDTH-1:0] actual);
        if (actual !== expected) begin
            errorCount++;
            $display("Fail at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
        end
    endtask

    task automatic checkOutputs(input stateT expState, input logic [6:0] lines,
                                input logic [`ALU_OP_WIDTH-1:0] alu);
        checkState("state", expState, state);
        checkCtrl("rfLoad", 4'(lines[6]), 4'(rfLoad));
        checkCtrl("irLoad", 4'(lines[5]), 4'(irLoad));
        checkCtrl("marLoad", 4'(lines[4]), 4'(marLoad));
        checkCtrl("mdrLoad", 4'(lines[3]), 4'(mdrLoad));
        checkCtrl("memRw", 4'(lines[2]), 4'(memRw));
        checkCtrl("memValid", 4'(lines[1]), 4'(memValid));
        checkCtrl("srLoad", 4'(lines[0]), 4'(srLoad));
        checkCtrl("aluOp", alu, aluOp);
    endtask

    task automatic waitForState(input stateT target);
        int waited;
        waited = 0;
        @(negedge CLK);
        while (state !== target && waited < waitLimit) begin
            @(negedge CLK);
            waited++;
        end
        if (state !== target) begin
            errorCount++;
            $display("Error at %0t: state never reached %0d", $time, target);
        end
    endtask

    task automatic reportTest(input string name, input int errorsBefore);
        testCount++;
        if (errorCount == errorsBefore) begin
            $display("Test %s passed", name);
        end else begin
            failedTests++;
            $display("Test %s failed with %0d errors", name, errorCount - errorsBefore);
        end
    endtask

    // Walks states 1 to 3, holds moc low for waitCycles, ends with state 4 showing
    task automatic runFetch(input instrT word, input int waitCycles, input logic cond);
        @(posedge CLK);
        instr    <= word;
        condPass <= cond;
        moc      <= 1'b0;
        waitForState(`ST_FETCH1);
        checkOutputs(`ST_FETCH1, linesFetch1, aluNone);
        @(negedge CLK);
        checkOutputs(`ST_FETCH2, linesFetch2, aluNone);
        @(negedge CLK);
        checkOutputs(`ST_FETCH3, linesFetch3, aluNone);
        repeat (waitCycles) begin
            @(negedge CLK);
            checkOutputs(`ST_FETCH3, linesFetch3, aluNone);   // Still waiting
        end
        @(posedge CLK);
        moc <= 1'b1;
        @(negedge CLK);
        checkOutputs(`ST_FETCH3, linesFetch3, aluNone);
        @(posedge CLK);
        moc <= 1'b0;                                          // Seen high on this edge
        @(negedge CLK);
        checkOutputs(`ST_FETCH3, linesFetch3, aluNone);      // Output lags the register
        @(negedge CLK);
        checkOutputs(`ST_COND, linesNone, aluNone);
    endtask

    task automatic runExec(input instrT word, input stateT expState, input logic [6:0] lines,
                           input logic [`ALU_OP_WIDTH-1:0] alu);
        runFetch(word, 0, 1'b1);
        @(negedge CLK);
        checkOutputs(expState, lines, alu);
        @(negedge CLK);
        checkOutputs(`ST_FETCH0, linesNone, aluNone);
    endtask

    task automatic runSkipped(input instrT word, input logic cond);
        runFetch(word, 0, cond);
        @(negedge CLK);
        checkOutputs(`ST_FETCH0, linesNone, aluNone);
    endtask

    task automatic testReset();
        int errorsBefore;
        errorsBefore = errorCount;
        repeat (2) begin
            @(negedge CLK);
            checkOutputs(`ST_FETCH0, linesNone, aluNone);
        end
        @(posedge CLK);
        CLR <= 1'b1;
        @(negedge CLK);
        checkOutputs(`ST_FETCH0, linesNone, aluNone);
        reportTest("reset", errorsBefore);
    endtask

    task automatic testFetch();
        int errorsBefore;
        errorsBefore = errorCount;
        runSkipped(dpInstr(3'b000, opAdd, 12'h012), 1'b0);
        reportTest("fetch", errorsBefore);
    endtask

    task automatic testMemWait();
        int errorsBefore;
        int delay;
        errorsBefore = errorCount;
        delay = 1 + ($random(mocSeed) & 7);   // 1 to 8 cycles
        runFetch(dpInstr(3'b000, opAdd, 12'h002), delay, 1'b0);
        @(negedge CLK);
        checkOutputs(`ST_FETCH0, linesNone, aluNone);
        reportTest("memory wait", errorsBefore);
    endtask

    task automatic testDataProc();
        int errorsBefore;
        errorsBefore = errorCount;
        runExec(dpInstr(3'b000, opAdd, 12'h012), `ST_ALU_REG, linesRf, aluArith);
        runExec(dpInstr(3'b000, opCmp, 12'h012), `ST_TEST_REG, linesSr, aluTest);
        runExec(dpInstr(3'b000, opAdd, 12'h0A2), `ST_ALU_SHIFT, linesRf, aluArith);
        runExec(dpInstr(3'b000, opCmp, 12'h0A2), `ST_TEST_SHIFT, linesSr, aluTest);
        runExec(dpInstr(3'b001, opAdd, 12'h0FF), `ST_ALU_IMM, linesRf, aluArith);
        runExec(dpInstr(3'b001, opCmp, 12'h0FF), `ST_TEST_IMM, linesSr, aluTest);
        reportTest("data processing", errorsBefore);
    endtask

    task automatic testBranch();
        int errorsBefore;
        errorsBefore = errorCount;
        runExec(brInstr(1'b0), `ST_BRANCH, linesNone, aluNone);
        runExec(brInstr(1'b1), `ST_BRANCH_LINK, linesRf, aluNone);
        reportTest("branch", errorsBefore);
    endtask

    task automatic testCondition();
        int errorsBefore;
        errorsBefore = errorCount;
        runSkipped(dpInstr(3'b000, opAdd, 12'h012), 1'b0);   // Condition fails
        runSkipped(dpInstr(3'b010, opAdd, 12'h004), 1'b1);   // Load/store class
        reportTest("condition and unsupported class", errorsBefore);
    endtask

    initial begin : watchdog
        cycleCount = 0;
        while (cycleCount < cycleLimit) begin
            @(posedge CLK);
            cycleCount++;
        end
        errorCount++;
        $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
        $display("Done: errors found");
        $finish;
    end

    initial begin
        CLR      = 1'b0;
        instr    = '0;
        moc      = 1'b0;
        condPass = 1'b0;
        testReset();
        testFetch();
        testMemWait();
        testDataProc();
        testBranch();
        testCondition();
        $display("Tests: %0d run, %0d failed, %0d errors", testCount, failedTests, errorCount);
        if (errorCount == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// ==== controlUnit.f ====
+incdir+.
instrPkg.sv
microcodePkg.sv
instrDecoder.sv
microSequencer.sv
controlStore.sv
controlUnit.sv
tbControlUnit.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --timescale 1ns/1ps -j 0
TOP       = tbControlUnit
FILELIST  = controlUnit.f
OBJDIR    = obj_dir
PASS_MSG  = Done: no errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: compile
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)
